/* disp_decoder.f */
logic/disp_decode_pkg.sv
logic/prefix_scan.sv
logic/modrm_locate.sv
logic/disp_select.sv
logic/disp_extract.sv
logic/disp_decoder.sv
test/disp_decoder_tb.sv

/* logic/disp_decode_pkg.sv */
package disp_decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // Window geometry and prefix bytes
    //////////////////////////////////////////////////////////////////////

    localparam int window_bytes = 16;
    localparam int max_prefixes = 3;   // Prefixes beyond this are not decoded.

    localparam logic [7:0] opcode_escape    = 8'h0F;
    localparam logic [7:0] prefix_addr_size = 8'h67;

    // Legacy prefixes other than the address-size override.
    localparam int legacy_prefix_count = 10;
    localparam logic [legacy_prefix_count-1:0][7:0] legacy_prefixes = {
        8'h66, 8'hF0, 8'hF2, 8'hF3, 8'h2E,
        8'h36, 8'h3E, 8'h26, 8'h64, 8'h65
    };

    //////////////////////////////////////////////////////////////////////
    // ModRM field values
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] mod_mem       = 2'b00;
    localparam logic [1:0] mod_disp8     = 2'b01;
    localparam logic [1:0] mod_disp_full = 2'b10;
    localparam logic [1:0] mod_reg       = 2'b11;

    localparam logic [2:0] rm_sib    = 3'b100;   // SIB follows in 32-bit addressing.
    localparam logic [2:0] rm_disp32 = 3'b101;
    localparam logic [2:0] rm_disp16 = 3'b110;

    // Bit positions in the one-hot size select.
    localparam int size_none  = 0;
    localparam int size_byte  = 1;
    localparam int size_word  = 2;
    localparam int size_dword = 3;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Byte 0 sits in the low bits.
    typedef logic [window_bytes-1:0][7:0] window_t;

    typedef struct packed {
        logic [max_prefixes:0] count_onehot;   // Bit k set means k prefixes.
        logic                  addr_override;
    } prefix_info_t;

    typedef struct packed {
        logic       double_opcode;
        logic       has_modrm;
        logic [1:0] mod;
        logic [2:0] rm;
        logic       has_sib;
    } modrm_info_t;

    // Bit 0 is no ModRM; bit k puts the displacement at byte k+1.
    typedef logic [6:0] disp_sel_t;

    typedef logic [3:0] disp_size_t;

    typedef struct packed {
        logic [31:0] disp;          // Sign-extended.
        logic [2:0]  disp_len;      // In bytes, zero when absent.
        logic [2:0]  disp_offset;   // Zero when absent.
        logic        has_disp;
    } disp_result_t;

endpackage

/* logic/disp_decoder.sv */
`timescale 1ns/1ns

module disp_decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  disp_decode_pkg::window_t      window,
    output logic                          out_valid,
    output disp_decode_pkg::disp_result_t result
);

    logic                          in_valid_q;
    disp_decode_pkg::window_t      window_q;
    disp_decode_pkg::prefix_info_t prefix_info;
    disp_decode_pkg::modrm_info_t  modrm_info;
    disp_decode_pkg::disp_sel_t    disp_sel;
    disp_decode_pkg::disp_size_t   disp_size;

    logic                          stage_valid;
    disp_decode_pkg::window_t      stage_window;
    disp_decode_pkg::disp_sel_t    stage_sel;
    disp_decode_pkg::disp_size_t   stage_size;
    disp_decode_pkg::disp_result_t extract_result;

    //////////////////////////////////////////////////////////////////////
    // Stage 1: locate the displacement
    //////////////////////////////////////////////////////////////////////

    prefix_scan prefix_scan_i (.window(window_q), .prefix_info(prefix_info));

    modrm_locate modrm_locate_i (
        .window      (window_q),
        .prefix_info (prefix_info),
        .modrm_info  (modrm_info)
    );

    disp_select disp_select_i (
        .prefix_info (prefix_info),
        .modrm_info  (modrm_info),
        .disp_sel    (disp_sel),
        .disp_size   (disp_size)
    );

    //////////////////////////////////////////////////////////////////////
    // Stage 2: extract
    //////////////////////////////////////////////////////////////////////

    disp_extract disp_extract_i (
        .window    (stage_window),
        .disp_sel  (stage_sel),
        .disp_size (stage_size),
        .result    (extract_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid_q  <= 1'b0;
            stage_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            in_valid_q  <= in_valid;
            stage_valid <= in_valid_q;
            out_valid   <= stage_valid;   // A single-cycle pulse per window.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) window_q <= window;
        if (in_valid_q) begin
            stage_window <= window_q;
            stage_sel    <= disp_sel;
            stage_size   <= disp_size;
        end
        if (stage_valid) result <= extract_result;
    end

endmodule

/* logic/disp_extract.sv */
`timescale 1ns/1ns

module disp_extract (
    input  disp_decode_pkg::window_t      window,
    input  disp_decode_pkg::disp_sel_t    disp_sel,
    input  disp_decode_pkg::disp_size_t   disp_size,
    output disp_decode_pkg::disp_result_t result
);

    logic [disp_decode_pkg::window_bytes*8-1:0] flat;
    logic [31:0] raw;            // Four bytes from the start position up.
    logic [31:0] ext_byte;
    logic [31:0] ext_word;
    logic [2:0]  offset;
    logic        has_disp;

    assign flat = window;

    //////////////////////////////////////////////////////////////////////
    // Byte alignment
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        raw    = '0;
        offset = '0;
        for (int k = 1; k < $bits(disp_decode_pkg::disp_sel_t); k++) begin
            raw    |= flat[8*(k+1) +: 32] & {32{disp_sel[k]}};
            offset |= 3'(k + 1) & {3{disp_sel[k]}};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sign extension
    //////////////////////////////////////////////////////////////////////

    assign ext_byte = {{24{raw[7]}}, raw[7:0]};
    assign ext_word = {{16{raw[15]}}, raw[15:0]};

    assign has_disp = ~disp_size[disp_decode_pkg::size_none] & ~disp_sel[0];

    assign result.disp = (ext_byte & {32{disp_size[disp_decode_pkg::size_byte]}})
                       | (ext_word & {32{disp_size[disp_decode_pkg::size_word]}})
                       | (raw      & {32{disp_size[disp_decode_pkg::size_dword]}});

    // The one-hot size doubles as the binary length 1, 2 or 4.
    assign result.disp_len = {disp_size[disp_decode_pkg::size_dword],
                              disp_size[disp_decode_pkg::size_word],
                              disp_size[disp_decode_pkg::size_byte]};

    assign result.disp_offset = offset & {3{has_disp}};
    assign result.has_disp    = has_disp;

endmodule

/* logic/disp_select.sv */
`timescale 1ns/1ns

module disp_select (
    input  disp_decode_pkg::prefix_info_t prefix_info,
    input  disp_decode_pkg::modrm_info_t  modrm_info,
    output disp_decode_pkg::disp_sel_t    disp_sel,
    output disp_decode_pkg::disp_size_t   disp_size
);

    logic [disp_decode_pkg::max_prefixes:0] p;
    logic dbl;
    logic sib;
    logic has_modrm;
    logic ovr;
    logic mod_is_mem;
    logic mod_is_disp8;
    logic mod_is_full;
    logic full_size;   // mod 10, or the mod 00 special case.

    assign p         = prefix_info.count_onehot;
    assign ovr       = prefix_info.addr_override;
    assign dbl       = modrm_info.double_opcode;
    assign sib       = modrm_info.has_sib;
    assign has_modrm = modrm_info.has_modrm;

    //////////////////////////////////////////////////////////////////////
    // Start position
    //////////////////////////////////////////////////////////////////////

    // Bit k is taken when prefixes plus double plus SIB add up to k-1.
    assign disp_sel[0] = ~has_modrm;

    assign disp_sel[1] = has_modrm & (p[0] & ~dbl & ~sib);

    assign disp_sel[2] = has_modrm & ((p[0] &  dbl & ~sib)
                                    | (p[0] & ~dbl &  sib)
                                    | (p[1] & ~dbl & ~sib));

    assign disp_sel[3] = has_modrm & ((p[0] &  dbl &  sib)
                                    | (p[1] &  dbl & ~sib)
                                    | (p[1] & ~dbl &  sib)
                                    | (p[2] & ~dbl & ~sib));

    assign disp_sel[4] = has_modrm & ((p[1] &  dbl &  sib)
                                    | (p[2] &  dbl & ~sib)
                                    | (p[2] & ~dbl &  sib)
                                    | (p[3] & ~dbl & ~sib));

    assign disp_sel[5] = has_modrm & ((p[2] &  dbl &  sib)
                                    | (p[3] &  dbl & ~sib)
                                    | (p[3] & ~dbl &  sib));

    assign disp_sel[6] = has_modrm & (p[3] & dbl & sib);

    //////////////////////////////////////////////////////////////////////
    // Width
    //////////////////////////////////////////////////////////////////////

    assign mod_is_mem   = has_modrm && (modrm_info.mod == disp_decode_pkg::mod_mem);
    assign mod_is_disp8 = has_modrm && (modrm_info.mod == disp_decode_pkg::mod_disp8);
    assign mod_is_full  = has_modrm && (modrm_info.mod == disp_decode_pkg::mod_disp_full);

    always_comb begin
        if (ovr) begin
            full_size = mod_is_full
                      || (mod_is_mem && (modrm_info.rm == disp_decode_pkg::rm_disp16));
        end else begin
            full_size = mod_is_full
                      || (mod_is_mem && (modrm_info.rm == disp_decode_pkg::rm_disp32));
        end
    end

    assign disp_size[disp_decode_pkg::size_byte]  = mod_is_disp8;
    assign disp_size[disp_decode_pkg::size_word]  = full_size & ovr;
    assign disp_size[disp_decode_pkg::size_dword] = full_size & ~ovr;
    assign disp_size[disp_decode_pkg::size_none]  = ~(mod_is_disp8 | full_size);   // Mod 11 too.

endmodule

/* logic/modrm_locate.sv */
`timescale 1ns/1ns

module modrm_locate (
    input  disp_decode_pkg::window_t      window,
    input  disp_decode_pkg::prefix_info_t prefix_info,
    output disp_decode_pkg::modrm_info_t  modrm_info
);

    logic [7:0] opcode;        // First opcode byte.
    logic [7:0] next_byte;     // Second opcode byte or ModRM.
    logic [7:0] third_byte;    // ModRM after a two-byte opcode.
    logic [7:0] modrm;
    logic       double_opcode;
    logic       one_byte_modrm;
    logic       two_byte_modrm;
    logic       has_modrm;

    //////////////////////////////////////////////////////////////////////
    // Opcode byte select by the one-hot prefix count
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        opcode     = '0;
        next_byte  = '0;
        third_byte = '0;
        for (int k = 0; k <= disp_decode_pkg::max_prefixes; k++) begin
            opcode     |= window[k]   & {8{prefix_info.count_onehot[k]}};
            next_byte  |= window[k+1] & {8{prefix_info.count_onehot[k]}};
            third_byte |= window[k+2] & {8{prefix_info.count_onehot[k]}};
        end
    end

    assign double_opcode = (opcode == disp_decode_pkg::opcode_escape);

    //////////////////////////////////////////////////////////////////////
    // ModRM tables
    //////////////////////////////////////////////////////////////////////

    // ALU ops in 00-3F with bit 2 clear, then the group and move opcodes.
    assign one_byte_modrm = ((opcode[7:6] == 2'b00) && !opcode[2])
                          || (opcode[7:4] == 4'h8)
                          || (opcode inside {8'hC0, 8'hC1, 8'hC6, 8'hC7,
                                             8'hD0, 8'hD1, 8'hD2, 8'hD3,
                                             8'hF6, 8'hF7, 8'hFE, 8'hFF});

    // CMOVcc, IMUL and the MOVZX/MOVSX forms.
    assign two_byte_modrm = (next_byte[7:4] == 4'h4)
                          || (next_byte inside {8'hAF, 8'hB6, 8'hB7, 8'hBE, 8'hBF});

    assign has_modrm = double_opcode ? two_byte_modrm : one_byte_modrm;
    assign modrm     = double_opcode ? third_byte : next_byte;

    assign modrm_info.double_opcode = double_opcode;
    assign modrm_info.has_modrm     = has_modrm;
    assign modrm_info.mod           = modrm[7:6];
    assign modrm_info.rm            = modrm[2:0];

    // 16-bit addressing never takes a SIB byte.
    assign modrm_info.has_sib = has_modrm
                              && !prefix_info.addr_override
                              && (modrm[7:6] != disp_decode_pkg::mod_reg)
                              && (modrm[2:0] == disp_decode_pkg::rm_sib);

endmodule

/* logic/prefix_scan.sv */
`timescale 1ns/1ns

module prefix_scan (
    input  disp_decode_pkg::window_t      window,
    output disp_decode_pkg::prefix_info_t prefix_info
);

    logic [disp_decode_pkg::max_prefixes-1:0] is_prefix;
    logic [disp_decode_pkg::max_prefixes-1:0] is_addr;
    logic [disp_decode_pkg::max_prefixes-1:0] run;   // Bytes 0 to i are all prefixes.

    function automatic logic is_legacy(input logic [7:0] value);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < disp_decode_pkg::legacy_prefix_count; j++) begin
            hit |= (value == disp_decode_pkg::legacy_prefixes[j]);
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Byte classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < disp_decode_pkg::max_prefixes; i++) begin
            is_addr[i]   = (window[i] == disp_decode_pkg::prefix_addr_size);
            is_prefix[i] = is_addr[i] | is_legacy(window[i]);
        end
    end

    // The scan stops at the first byte that is not a prefix.
    always_comb begin
        run[0] = is_prefix[0];
        for (int i = 1; i < disp_decode_pkg::max_prefixes; i++) begin
            run[i] = run[i-1] & is_prefix[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // One-hot count
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        prefix_info.count_onehot[0] = ~is_prefix[0];
        for (int k = 1; k < disp_decode_pkg::max_prefixes; k++) begin
            prefix_info.count_onehot[k] = run[k-1] & ~is_prefix[k];
        end
        prefix_info.count_onehot[disp_decode_pkg::max_prefixes] =
            run[disp_decode_pkg::max_prefixes-1];
    end

    assign prefix_info.addr_override = |(run & is_addr);   // Only counted bytes matter.

endmodule

/* run.sh */
#!/bin/sh
# Builds the displacement decoder testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir \
    --top-module disp_decoder_tb -f disp_decoder.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vdisp_decoder_tb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* test/disp_decoder_tb.sv */
`timescale 1ns/1ns

module disp_decoder_tb;

    localparam int clk_period      = 100;
    localparam int total_windows   = 172;
    localparam int gap_cycles      = 90;    // Idle cycles the tests insert.
    localparam int drain_cycles    = 36;    // About six per test.
    localparam int watchdog_cycles = total_windows + gap_cycles + drain_cycles + 3 + 20;

    // Index 0 is the address-size override, 1 to 10 the other legacy prefixes.
    localparam logic [10:0][7:0] prefix_values = {
        8'h65, 8'h64, 8'h26, 8'h3E, 8'h36, 8'h2E, 8'hF3, 8'hF2, 8'hF0, 8'h66, 8'h67
    };
    localparam logic [11:0][7:0] group_ops = {
        8'hC0, 8'hC1, 8'hC6, 8'hC7, 8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hF6, 8'hF7, 8'hFE, 8'hFF
    };
    localparam logic [19:0][7:0] plain_ops = {   // One-byte opcodes without ModRM.
        8'h04, 8'h05, 8'h0C, 8'h0D, 8'h14, 8'h1C, 8'h24, 8'h2C, 8'h34, 8'h3C,
        8'h40, 8'h48, 8'h50, 8'h58, 8'h6A, 8'h70, 8'h90, 8'hA8, 8'hB8, 8'hC3
    };
    localparam logic [4:0][7:0] ext_modrm_ops = {8'hAF, 8'hB6, 8'hB7, 8'hBE, 8'hBF};
    localparam logic [7:0][7:0] ext_plain_ops = {
        8'h05, 8'h0B, 8'h31, 8'h80, 8'h84, 8'h8F, 8'hA2, 8'hC8
    };

    typedef struct packed {
        int                            id;
        int                            due;   // Cycle in which out_valid must show.
        disp_decode_pkg::disp_result_t res;
    } expected_t;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          in_valid;
    disp_decode_pkg::window_t      window;
    logic                          out_valid;
    disp_decode_pkg::disp_result_t result;

    expected_t   exp_q[$];
    logic [31:0] rng_state    = 32'd56436;
    int          cycle        = 0;
    int          errors       = 0;
    int          sent         = 0;
    int          checked      = 0;
    int          test_windows = 0;

    disp_decoder dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .window    (window),
        .out_valid (out_valid),
        .result    (result)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // Random numbers and window building
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [7:0] pick_one_byte_op(input logic modrm_on);
        logic [31:0] r;
        r = rand_word();
        if (!modrm_on) return plain_ops[5'(r % 20)];
        case (r[9:8])
            2'd0, 2'd1: return {2'b00, r[5:3], 1'b0, r[1:0]};   // ALU forms.
            2'd2:       return {4'h8, r[3:0]};
            default:    return group_ops[4'(r % 12)];
        endcase
    endfunction

    function automatic logic [7:0] pick_ext_op(input logic modrm_on);
        logic [31:0] r;
        r = rand_word();
        if (!modrm_on) return ext_plain_ops[3'(r % 8)];
        if (r[8]) return {4'h4, r[3:0]};   // CMOVcc.
        return ext_modrm_ops[3'(r % 5)];
    endfunction

    function automatic disp_decode_pkg::window_t build_window(
        input int n_pref, input logic addr, input logic dbl, input logic modrm_on,
        input logic [1:0] md, input logic [2:0] rm);
        disp_decode_pkg::window_t w;
        logic [31:0] r;
        int          addr_pos;
        int          pos;
        for (int i = 0; i < 16; i++) begin
            w[4'(i)] = 8'(rand_word());
        end
        r = rand_word();
        addr_pos = (addr && n_pref > 0) ? int'(r % n_pref) : -1;
        for (int i = 0; i < n_pref; i++) begin
            r = rand_word();
            w[4'(i)] = (i == addr_pos) ? prefix_values[0] : prefix_values[4'(1 + r % 10)];
        end
        pos = n_pref;
        if (dbl) begin
            w[4'(pos)]     = 8'h0F;
            w[4'(pos + 1)] = pick_ext_op(modrm_on);
            pos = pos + 2;
        end else begin
            w[4'(pos)] = pick_one_byte_op(modrm_on);
            pos = pos + 1;
        end
        r = rand_word();
        if (modrm_on) w[4'(pos)] = {md, r[5:3], rm};   // Reg field is random.
        return w;
    endfunction

    function automatic disp_decode_pkg::window_t random_window();
        logic [31:0] r;
        int          n;
        r = rand_word();
        n = int'(r % 4);
        return build_window(n, n > 0 && r[4:3] == 2'd0, r[5], r[7:6] != 2'd0,
                            r[9:8], r[12:10]);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic is_prefix_byte(input logic [7:0] b);
        for (int i = 0; i < 11; i++) begin
            if (b == prefix_values[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic one_byte_has_modrm(input logic [7:0] op);
        return (op < 8'h40 && op[2] == 1'b0) || (op >= 8'h80 && op <= 8'h8F)
            || (op inside {8'hC0, 8'hC1, 8'hC6, 8'hC7, 8'hD0, 8'hD1, 8'hD2, 8'hD3,
                           8'hF6, 8'hF7, 8'hFE, 8'hFF});
    endfunction

    function automatic logic two_byte_has_modrm(input logic [7:0] op);
        return (op >= 8'h40 && op <= 8'h4F) || (op inside {8'hAF, 8'hB6, 8'hB7, 8'hBE, 8'hBF});
    endfunction

    function automatic disp_decode_pkg::disp_result_t decode_ref(
        input disp_decode_pkg::window_t w);
        disp_decode_pkg::disp_result_t r;
        int          n;
        int          opl;
        int          len;
        int          off;
        logic        stop;
        logic        ovr;
        logic        dbl;
        logic        modrm_present;
        logic        sib;
        logic [7:0]  modrm;
        logic [1:0]  md;
        logic [2:0]  rm;
        logic [31:0] raw;
        n    = 0;
        stop = 1'b0;
        ovr  = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!stop && is_prefix_byte(w[4'(i)])) begin
                if (w[4'(i)] == 8'h67) ovr = 1'b1;
                n++;
            end else begin
                stop = 1'b1;
            end
        end
        dbl = (w[4'(n)] == 8'h0F);
        opl = dbl ? 2 : 1;
        modrm_present = dbl ? two_byte_has_modrm(w[4'(n + 1)]) : one_byte_has_modrm(w[4'(n)]);
        modrm = w[4'(n + opl)];
        md    = modrm[7:6];
        rm    = modrm[2:0];
        sib   = modrm_present && !ovr && md != 2'b11 && rm == 3'b100;
        len   = 0;
        if (modrm_present) begin
            case (md)
                2'b01: len = 1;
                2'b10: len = ovr ? 2 : 4;
                2'b00: begin
                    if (ovr && rm == 3'b110) len = 2;
                    else if (!ovr && rm == 3'b101) len = 4;
                end
                default: len = 0;
            endcase
        end
        r = '0;
        if (len != 0) begin
            off = n + opl + 1 + (sib ? 1 : 0);
            raw = {w[4'(off + 3)], w[4'(off + 2)], w[4'(off + 1)], w[4'(off)]};
            case (len)
                1:       r.disp = {{24{raw[7]}}, raw[7:0]};
                2:       r.disp = {{16{raw[15]}}, raw[15:0]};
                default: r.disp = raw;
            endcase
            r.disp_len    = 3'(len);
            r.disp_offset = 3'(off);
            r.has_disp    = 1'b1;
        end
        return r;
    endfunction

    function automatic string result_text(input disp_decode_pkg::disp_result_t r);
        return $sformatf("disp=%h len=%0d off=%0d has=%b",
                         r.disp, r.disp_len, r.disp_offset, r.has_disp);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Driving
    //////////////////////////////////////////////////////////////////////

    task automatic send_window(input disp_decode_pkg::window_t w);
        expected_t e;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        window   = w;
        e.id  = sent;
        e.due = cycle + 3;   // Sampled at the next edge, out two edges later.
        e.res = decode_ref(w);
        exp_q.push_back(e);
        sent++;
        test_windows++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        idle(1);
        while (exp_q.size() != 0) @(posedge clk);
        $display("%-16s %3d windows, %0d errors", name, test_windows, errors - errors_before);
        test_windows = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_latency();
        int e0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            send_window(random_window());
            idle(1 + i);
        end
        finish_test("reset_latency", e0);
    endtask

    task automatic test_no_disp();
        int e0;
        int n;
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            n = (i / 4) % 4;
            send_window(build_window(n, i >= 12 && n != 0, i[0], i[1], 2'b11,
                                     3'(rand_word())));
        end
        finish_test("no_disp", e0);
    endtask

    task automatic test_mod01_mod10();
        int         e0;
        logic [2:0] rm;
        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            for (int k = 0; k < 8; k++) begin
                rm = 3'(rand_word());
                if (rm == 3'b100) rm = 3'b101;
                if (k[1]) rm = 3'b100;   // SIB present.
                send_window(build_window(n, 1'b0, k[0], 1'b1, k[2] ? 2'b10 : 2'b01, rm));
            end
        end
        finish_test("mod01_mod10", e0);
    endtask

    task automatic test_addr_override();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            case (i % 4)
                0: send_window(build_window(1 + i % 3, 1'b1, i[2], 1'b1, 2'b00, 3'b110));
                1: send_window(build_window(1 + i % 3, 1'b1, i[2], 1'b1, 2'b00,
                                            (i < 8) ? 3'b100 : 3'b101));
                2: send_window(build_window(1 + i % 3, 1'b1, i[2], 1'b1, 2'b01, 3'b100));
                default: send_window(build_window(1 + i % 3, 1'b1, i[2], 1'b1, 2'b10, 3'b100));
            endcase
        end
        finish_test("addr_override", e0);
    endtask

    task automatic test_mod00_32bit();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            send_window(build_window(int'(rand_word() % 4), 1'b0, i[3], 1'b1, 2'b00, 3'(i)));
        end
        finish_test("mod00_32bit", e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        e0 = errors;
        for (int i = 0; i < 40; i++) send_window(random_window());
        for (int i = 0; i < 40; i++) begin
            send_window(random_window());
            idle(int'(rand_word() % 3));
        end
        finish_test("back_to_back", e0);
    endtask

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        window   = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_latency();
        test_no_disp();
        test_mod01_mod10();
        test_addr_override();
        test_mod00_32bit();
        test_back_to_back();
        $display("Summary: 6 tests, %0d windows sent, %0d checked, %0d errors",
                 sent, checked, errors);
        if (errors == 0 && checked == sent) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : check_outputs
        expected_t head;
        if (reset) begin
            assert (out_valid == 1'b0) else begin
                $display("FAILED at %0t ns: out_valid high during reset", $time);
                errors++;
            end
        end else if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("FAILED at %0t ns: out_valid with no window in flight", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checked++;
                assert (head.due == cycle) else begin
                    $display("FAILED at %0t ns: window %0d out in cycle %0d, expected %0d",
                             $time, head.id, cycle, head.due);
                    errors++;
                end
                assert (result == head.res) else begin
                    $display("FAILED at %0t ns: window %0d gave %s, expected %s",
                             $time, head.id, result_text(result), result_text(head.res));
                    errors++;
                end
            end
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle) else begin
                $display("Window %0d gave no output by cycle %0d", exp_q[0].id, cycle);
                errors++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired at %0t ns with %0d windows still in flight",
                 $time, exp_q.size());
        $display("test failed");
        $finish;
    end

endmodule
